//--- adc_pkg.sv
// Shared definitions for the receive capture core
// Sample and lane types, packer and FIFO sizing
// AXI4-Lite register map, response codes and ID value

`default_nettype none

package adc_pkg;

  // Sample path sizing
  localparam int NUM_CHANNELS = 4;
  localparam int SAMPLE_W     = 16;
  localparam int WORD_W       = NUM_CHANNELS * SAMPLE_W;
  // Packer fill count holds up to two words worth of lanes
  localparam int FILL_W       = $clog2(2 * NUM_CHANNELS);

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  // Lane 0 sits in the least significant bits
  typedef sample_t [NUM_CHANNELS-1:0] lanes_t;

  // Word FIFO
  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

  // **************************************************************************
  // Register port
  // **************************************************************************
  localparam int AXI_AW = 32;
  localparam int AXI_DW = 32;

  localparam logic [AXI_AW-1:0] REG_ID          = 32'h0000_0000;
  localparam logic [AXI_AW-1:0] REG_CHAN_ENABLE = 32'h0000_0004;
  localparam logic [AXI_AW-1:0] REG_STATUS      = 32'h0000_0008;
  localparam logic [AXI_AW-1:0] REG_WORD_COUNT  = 32'h0000_000C;

  // ASCII "ADC1"
  localparam logic [AXI_DW-1:0] CORE_ID = 32'h4144_4331;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  localparam logic [NUM_CHANNELS-1:0] ENABLE_RESET = '1;

endpackage

`default_nettype wire

//--- adc_regs.sv
// AXI4-Lite register block for the capture path
// Channel enables, sticky overflow flag, stored word counter, ID

`timescale 1ns/10ps
`default_nettype none

module adc_regs
  import adc_pkg::*;
(
  input  logic                    axi_aclk,
  input  logic                    rst_n,

  input  logic                    s_axi_awvalid,
  output logic                    s_axi_awready,
  input  logic [AXI_AW-1:0]       s_axi_awaddr,
  input  logic                    s_axi_wvalid,
  output logic                    s_axi_wready,
  input  logic [AXI_DW-1:0]       s_axi_wdata,
  input  logic [AXI_DW/8-1:0]     s_axi_wstrb,
  output logic                    s_axi_bvalid,
  input  logic                    s_axi_bready,
  output logic [1:0]              s_axi_bresp,
  input  logic                    s_axi_arvalid,
  output logic                    s_axi_arready,
  input  logic [AXI_AW-1:0]       s_axi_araddr,
  output logic                    s_axi_rvalid,
  input  logic                    s_axi_rready,
  output logic [AXI_DW-1:0]       s_axi_rdata,
  output logic [1:0]              s_axi_rresp,

  output logic [NUM_CHANNELS-1:0] chan_enable,
  input  logic                    word_stored,
  input  logic                    word_dropped
);

  logic              aw_w_ready;
  logic              wr_en;
  logic              wr_apply;
  logic              wr_mapped;
  logic              rd_en;
  logic              rd_mapped;
  logic [AXI_DW-1:0] rd_word;
  logic              ovf_flag;
  logic [AXI_DW-1:0] word_count;

  // **************************************************************************
  // Write channel
  // **************************************************************************

  // Address and data are accepted together, one beat per response
  assign s_axi_awready = aw_w_ready;
  assign s_axi_wready  = aw_w_ready;

  assign wr_en    = aw_w_ready & s_axi_awvalid & s_axi_wvalid;
  assign wr_apply = wr_en & wr_mapped & s_axi_wstrb[0];

  always_comb begin
    wr_mapped = 1'b0;
    case (s_axi_awaddr)
      REG_ID, REG_CHAN_ENABLE, REG_STATUS, REG_WORD_COUNT: wr_mapped = 1'b1;
      default: wr_mapped = 1'b0;
    endcase
  end

  always_ff @(posedge axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      aw_w_ready   <= 1'b0;
      s_axi_bvalid <= 1'b0;
    end else begin
      aw_w_ready <= ~aw_w_ready & ~s_axi_bvalid & s_axi_awvalid & s_axi_wvalid;
      if (wr_en) begin
        s_axi_bvalid <= 1'b1;
      end else if (s_axi_bready) begin
        s_axi_bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (wr_en) begin
      s_axi_bresp <= wr_mapped ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // **************************************************************************
  // Register state
  // **************************************************************************
  always_ff @(posedge axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      chan_enable <= ENABLE_RESET;
      ovf_flag    <= 1'b0;
      word_count  <= '0;
    end else begin
      if (wr_apply && s_axi_awaddr == REG_CHAN_ENABLE) begin
        chan_enable <= s_axi_wdata[NUM_CHANNELS-1:0];
      end

      // New overflow beats a clear in the same cycle
      if (word_dropped) begin
        ovf_flag <= 1'b1;
      end else if (wr_apply && s_axi_awaddr == REG_STATUS && s_axi_wdata[0]) begin
        ovf_flag <= 1'b0;
      end

      // Any write clears, otherwise saturating count
      if (wr_apply && s_axi_awaddr == REG_WORD_COUNT) begin
        word_count <= '0;
      end else if (word_stored && word_count != '1) begin
        word_count <= word_count + 1'b1;
      end
    end
  end

  // **************************************************************************
  // Read channel
  // **************************************************************************
  assign rd_en = s_axi_arready & s_axi_arvalid;

  always_comb begin
    rd_mapped = 1'b1;
    rd_word   = '0;
    case (s_axi_araddr)
      REG_ID:          rd_word = CORE_ID;
      REG_CHAN_ENABLE: rd_word[NUM_CHANNELS-1:0] = chan_enable;
      REG_STATUS:      rd_word[0] = ovf_flag;
      REG_WORD_COUNT:  rd_word = word_count;
      default:         rd_mapped = 1'b0;
    endcase
  end

  always_ff @(posedge axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      s_axi_arready <= 1'b0;
      s_axi_rvalid  <= 1'b0;
    end else begin
      s_axi_arready <= ~s_axi_arready & ~s_axi_rvalid & s_axi_arvalid;
      if (rd_en) begin
        s_axi_rvalid <= 1'b1;
      end else if (s_axi_rready) begin
        s_axi_rvalid <= 1'b0;
      end
    end
  end

  // Unmapped reads return zero data from the mux default
  always_ff @(posedge axi_aclk) begin
    if (rd_en) begin
      s_axi_rdata <= rd_word;
      s_axi_rresp <= rd_mapped ? RESP_OKAY : RESP_SLVERR;
    end
  end

endmodule

`default_nettype wire

//--- adc_cpack.sv
// Channel packer
// Gathers enabled channel samples into full words in channel order,
// carries surplus lanes over and restarts on an enable change

`timescale 1ns/10ps
`default_nettype none

module adc_cpack
  import adc_pkg::*;
(
  input  logic                    axi_aclk,
  input  logic                    rst_n,
  input  logic [NUM_CHANNELS-1:0] chan_enable,
  input  logic                    adc_valid,
  input  lanes_t                  adc_data,
  output logic                    word_push,
  output lanes_t                  word_data
);

  logic [NUM_CHANNELS-1:0]      enable_q;
  logic                         enable_chg;
  logic [FILL_W-1:0]            fill_cnt;
  logic [FILL_W-1:0]            fill_eff;
  logic [FILL_W-1:0]            num_en;
  logic [FILL_W-1:0]            total;
  logic                         word_full;
  lanes_t                       acc;
  lanes_t                       compact;
  sample_t [2*NUM_CHANNELS-1:0] merged;

  // Partial word belongs to the old enables and is dropped
  assign enable_chg = (chan_enable != enable_q);
  assign fill_eff   = enable_chg ? '0 : fill_cnt;

  // **************************************************************************
  // Lane selection
  // **************************************************************************

  // Squeeze enabled samples to the low lanes
  always_comb begin
    compact = '0;
    num_en  = '0;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      if (chan_enable[c]) begin
        compact[num_en] = adc_data[c];
        num_en          = num_en + 1'b1;
      end
    end
  end

  // Held lanes first, then the new samples
  always_comb begin
    merged = '0;
    for (int i = 0; i < NUM_CHANNELS; i++) begin
      if (FILL_W'(i) < fill_eff) begin
        merged[i] = acc[i];
      end
    end
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      if (FILL_W'(c) < num_en) begin
        merged[fill_eff + FILL_W'(c)] = compact[c];
      end
    end
  end

  assign total     = fill_eff + num_en;
  assign word_full = (total >= FILL_W'(NUM_CHANNELS));

  // **************************************************************************
  // Fill state
  // **************************************************************************
  always_ff @(posedge axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      enable_q  <= ENABLE_RESET;
      fill_cnt  <= '0;
      word_push <= 1'b0;
    end else begin
      enable_q  <= chan_enable;
      word_push <= adc_valid & word_full;
      if (adc_valid) begin
        if (word_full) begin
          fill_cnt <= total - FILL_W'(NUM_CHANNELS);
        end else begin
          fill_cnt <= total;
        end
      end else if (enable_chg) begin
        fill_cnt <= '0;
      end
    end
  end

  // Completed word out, upper lanes kept as the next partial
  always_ff @(posedge axi_aclk) begin
    if (adc_valid) begin
      if (word_full) begin
        word_data <= merged[NUM_CHANNELS-1:0];
        acc       <= merged[2*NUM_CHANNELS-1:NUM_CHANNELS];
      end else begin
        acc <= merged[NUM_CHANNELS-1:0];
      end
    end
  end

endmodule

`default_nettype wire

//--- adc_word_fifo.sv
// Synchronous word FIFO for packed words
// Valid/ready stream output, drop and store reporting on push

`timescale 1ns/10ps
`default_nettype none

module adc_word_fifo
  import adc_pkg::*;
(
  input  logic              axi_aclk,
  input  logic              rst_n,
  input  logic              word_push,
  input  lanes_t            word_data,
  output logic              word_stored,
  output logic              word_dropped,
  output logic              m_axis_valid,
  input  logic              m_axis_ready,
  output logic [WORD_W-1:0] m_axis_data
);

  lanes_t             mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW:0]   count;
  logic               full;
  logic               pop;
  logic               push_ok;

  assign full         = (count == FIFO_DEPTH);
  assign m_axis_valid = (count != '0);
  assign m_axis_data  = mem[rd_ptr];
  assign pop          = m_axis_valid & m_axis_ready;

  // A pop in the same cycle frees the slot for a push
  assign push_ok      = word_push & (~full | pop);
  assign word_stored  = push_ok;
  assign word_dropped = word_push & ~push_ok;

  always_ff @(posedge axi_aclk) begin
    if (push_ok) begin
      mem[wr_ptr] <= word_data;
    end
  end

  // Pointers wrap naturally at the power of two depth
  always_ff @(posedge axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push_ok, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- adc_capture_top.sv
// Receive capture top level
// Register block, channel packer and word FIFO

`timescale 1ns/10ps
`default_nettype none

module adc_capture_top
  import adc_pkg::*;
(
  input  logic                axi_aclk,
  input  logic                rst_n,

  input  logic                s_axi_awvalid,
  output logic                s_axi_awready,
  input  logic [AXI_AW-1:0]   s_axi_awaddr,
  input  logic                s_axi_wvalid,
  output logic                s_axi_wready,
  input  logic [AXI_DW-1:0]   s_axi_wdata,
  input  logic [AXI_DW/8-1:0] s_axi_wstrb,
  output logic                s_axi_bvalid,
  input  logic                s_axi_bready,
  output logic [1:0]          s_axi_bresp,
  input  logic                s_axi_arvalid,
  output logic                s_axi_arready,
  input  logic [AXI_AW-1:0]   s_axi_araddr,
  output logic                s_axi_rvalid,
  input  logic                s_axi_rready,
  output logic [AXI_DW-1:0]   s_axi_rdata,
  output logic [1:0]          s_axi_rresp,

  input  logic                adc_valid,
  input  lanes_t              adc_data,

  output logic                m_axis_valid,
  input  logic                m_axis_ready,
  output logic [WORD_W-1:0]   m_axis_data
);

  logic [NUM_CHANNELS-1:0] chan_enable;
  logic                    word_push;
  lanes_t                  word_data;
  logic                    word_stored;
  logic                    word_dropped;

  adc_regs u_regs (
    .axi_aclk      (axi_aclk),
    .rst_n         (rst_n),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .chan_enable   (chan_enable),
    .word_stored   (word_stored),
    .word_dropped  (word_dropped)
  );

  adc_cpack u_cpack (
    .axi_aclk    (axi_aclk),
    .rst_n       (rst_n),
    .chan_enable (chan_enable),
    .adc_valid   (adc_valid),
    .adc_data    (adc_data),
    .word_push   (word_push),
    .word_data   (word_data)
  );

  adc_word_fifo u_fifo (
    .axi_aclk     (axi_aclk),
    .rst_n        (rst_n),
    .word_push    (word_push),
    .word_data    (word_data),
    .word_stored  (word_stored),
    .word_dropped (word_dropped),
    .m_axis_valid (m_axis_valid),
    .m_axis_ready (m_axis_ready),
    .m_axis_data  (m_axis_data)
  );

endmodule

`default_nettype wire

//--- adc_capture_sva.sv
// Concurrent assertions for the capture core
// Stream word hold under stall, AXI4-Lite response hold, idle stream after reset

`timescale 1ns/10ps
`default_nettype none

module adc_capture_sva
  import adc_pkg::*;
(
  input logic              axi_aclk,
  input logic              rst_n,
  input logic              m_axis_valid,
  input logic              m_axis_ready,
  input logic [WORD_W-1:0] m_axis_data,
  input logic              s_axi_bvalid,
  input logic              s_axi_bready,
  input logic              s_axi_rvalid,
  input logic              s_axi_rready
);

  // Stalled word stays on the stream unchanged
  stream_hold: assert property (@(posedge axi_aclk) disable iff (!rst_n)
    m_axis_valid && !m_axis_ready |=> m_axis_valid && $stable(m_axis_data))
    else $error("stream word changed while stalled");

  bvalid_hold: assert property (@(posedge axi_aclk) disable iff (!rst_n)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
    else $error("bvalid dropped before bready");

  rvalid_hold: assert property (@(posedge axi_aclk) disable iff (!rst_n)
    s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid)
    else $error("rvalid dropped before rready");

  idle_after_reset: assert property (@(posedge axi_aclk)
    $rose(rst_n) |-> !m_axis_valid)
    else $error("m_axis_valid high right after reset");

endmodule

bind adc_capture_top adc_capture_sva u_sva (
  .axi_aclk     (axi_aclk),
  .rst_n        (rst_n),
  .m_axis_valid (m_axis_valid),
  .m_axis_ready (m_axis_ready),
  .m_axis_data  (m_axis_data),
  .s_axi_bvalid (s_axi_bvalid),
  .s_axi_bready (s_axi_bready),
  .s_axi_rvalid (s_axi_rvalid),
  .s_axi_rready (s_axi_rready)
);

`default_nettype wire

//--- tb_adc_capture.sv
// Testbench for the receive capture core
// Clock and reset, AXI4-Lite access tasks, sample driver,
// reference packing model, stream checker and test report

`timescale 1ns/10ps
`default_nettype none

module tb_adc_capture
  import adc_pkg::*;
();

  localparam int TIMEOUT       = 100;
  localparam int DRAIN_TIMEOUT = 2000;

  typedef enum {READY_RANDOM, READY_LOW, READY_HIGH} ready_mode_t;

  logic                axi_aclk;
  logic                rst_n;
  logic                s_axi_awvalid;
  logic                s_axi_awready;
  logic [AXI_AW-1:0]   s_axi_awaddr;
  logic                s_axi_wvalid;
  logic                s_axi_wready;
  logic [AXI_DW-1:0]   s_axi_wdata;
  logic [AXI_DW/8-1:0] s_axi_wstrb;
  logic                s_axi_bvalid;
  logic                s_axi_bready;
  logic [1:0]          s_axi_bresp;
  logic                s_axi_arvalid;
  logic                s_axi_arready;
  logic [AXI_AW-1:0]   s_axi_araddr;
  logic                s_axi_rvalid;
  logic                s_axi_rready;
  logic [AXI_DW-1:0]   s_axi_rdata;
  logic [1:0]          s_axi_rresp;
  logic                adc_valid;
  lanes_t              adc_data;
  logic                m_axis_valid;
  logic                m_axis_ready;
  logic [WORD_W-1:0]   m_axis_data;

  int                      errors = 0;
  int                      checks = 0;
  int                      rx_count = 0;
  ready_mode_t             ready_mode = READY_RANDOM;
  logic [NUM_CHANNELS-1:0] cur_en = ENABLE_RESET;
  // Reference model state
  logic [NUM_CHANNELS-1:0] model_en = ENABLE_RESET;
  sample_t                 model_q[$];
  logic [WORD_W-1:0]       expected_q[$];

  adc_capture_top u_adc_capture_top (
    .axi_aclk      (axi_aclk),
    .rst_n         (rst_n),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .adc_valid     (adc_valid),
    .adc_data      (adc_data),
    .m_axis_valid  (m_axis_valid),
    .m_axis_ready  (m_axis_ready),
    .m_axis_data   (m_axis_data)
  );

  initial begin
    axi_aclk = 1'b0;
  end

  always #2 axi_aclk = ~axi_aclk;

  // ************************************************************************
  // Checking and reference model
  // ************************************************************************
  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // Enabled samples queue up in channel order, four lanes per word
  function automatic void pack_model(input lanes_t sets[$],
                                     input logic [NUM_CHANNELS-1:0] en);
    lanes_t word;
    if (en != model_en) begin
      model_q.delete();
    end
    model_en = en;
    foreach (sets[i]) begin
      for (int c = 0; c < NUM_CHANNELS; c++) begin
        if (en[c]) begin
          model_q.push_back(sets[i][c]);
        end
      end
      while (model_q.size() >= NUM_CHANNELS) begin
        for (int k = 0; k < NUM_CHANNELS; k++) begin
          word[k] = model_q.pop_front();
        end
        expected_q.push_back(word);
      end
    end
  endfunction

  // Stream monitor, a transfer happens at the next rising edge
  always @(negedge axi_aclk) begin
    if (rst_n && m_axis_valid && m_axis_ready) begin
      rx_count++;
      if (expected_q.size() == 0) begin
        errors++;
        $display("Stream delivered a word that was not expected: 0x%0h", m_axis_data);
      end else begin
        check_value("m_axis_data", m_axis_data, expected_q.pop_front());
      end
    end
  end

  always @(posedge axi_aclk) begin
    #1;
    case (ready_mode)
      READY_LOW:  m_axis_ready = 1'b0;
      READY_HIGH: m_axis_ready = 1'b1;
      default:    m_axis_ready = (($urandom % 4) != 0);
    endcase
  end

  // ************************************************************************
  // Register access
  // ************************************************************************
  task automatic axi_write(input logic [AXI_AW-1:0] addr, input logic [AXI_DW-1:0] data,
                           output logic [1:0] resp);
    int n;
    resp          = 2'bxx;
    s_axi_awaddr  = addr;
    s_axi_wdata   = data;
    s_axi_wstrb   = '1;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid  = 1'b1;
    s_axi_bready  = 1'b0;
    n = 0;
    while (!(s_axi_awready && s_axi_wready) && n < TIMEOUT) begin
      @(posedge axi_aclk);
      #1;
      n++;
    end
    if (!(s_axi_awready && s_axi_wready)) begin
      errors++;
      $display("Write to 0x%0h timed out waiting for awready and wready", addr);
      s_axi_awvalid = 1'b0;
      s_axi_wvalid  = 1'b0;
      return;
    end
    @(posedge axi_aclk);
    #1;
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    n = 0;
    while (!s_axi_bvalid && n < TIMEOUT) begin
      @(posedge axi_aclk);
      #1;
      n++;
    end
    if (!s_axi_bvalid) begin
      errors++;
      $display("Write to 0x%0h timed out waiting for bvalid", addr);
      return;
    end
    // Response waits one cycle before bready
    @(posedge axi_aclk);
    #1;
    resp         = s_axi_bresp;
    s_axi_bready = 1'b1;
    @(posedge axi_aclk);
    #1;
    s_axi_bready = 1'b0;
  endtask

  task automatic axi_read(input logic [AXI_AW-1:0] addr, output logic [AXI_DW-1:0] data,
                          output logic [1:0] resp);
    int n;
    data          = 'x;
    resp          = 2'bxx;
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    s_axi_rready  = 1'b0;
    n = 0;
    while (!s_axi_arready && n < TIMEOUT) begin
      @(posedge axi_aclk);
      #1;
      n++;
    end
    if (!s_axi_arready) begin
      errors++;
      $display("Read of 0x%0h timed out waiting for arready", addr);
      s_axi_arvalid = 1'b0;
      return;
    end
    @(posedge axi_aclk);
    #1;
    s_axi_arvalid = 1'b0;
    n = 0;
    while (!s_axi_rvalid && n < TIMEOUT) begin
      @(posedge axi_aclk);
      #1;
      n++;
    end
    if (!s_axi_rvalid) begin
      errors++;
      $display("Read of 0x%0h timed out waiting for rvalid", addr);
      return;
    end
    // Read data waits one cycle before rready
    @(posedge axi_aclk);
    #1;
    data         = s_axi_rdata;
    resp         = s_axi_rresp;
    s_axi_rready = 1'b1;
    @(posedge axi_aclk);
    #1;
    s_axi_rready = 1'b0;
  endtask

  task automatic read_expect(input logic [AXI_AW-1:0] addr, input logic [AXI_DW-1:0] exp,
                             input logic [1:0] exp_resp, input string name);
    logic [AXI_DW-1:0] data;
    logic [1:0]        resp;
    axi_read(addr, data, resp);
    check_value(name, data, exp);
    check_value({name, " rresp"}, resp, exp_resp);
  endtask

  task automatic write_expect(input logic [AXI_AW-1:0] addr, input logic [AXI_DW-1:0] data,
                              input logic [1:0] exp_resp, input string name);
    logic [1:0] resp;
    axi_write(addr, data, resp);
    check_value({name, " bresp"}, resp, exp_resp);
  endtask

  task automatic set_enables(input logic [NUM_CHANNELS-1:0] en);
    write_expect(REG_CHAN_ENABLE, AXI_DW'(en), RESP_OKAY, "REG_CHAN_ENABLE write");
    cur_en = en;
  endtask

  // ************************************************************************
  // Sample stimulus
  // ************************************************************************

  // Model first so the expected words exist before the stream moves
  task automatic send_sample_sets(input int num, input int dropped);
    lanes_t sets[$];
    lanes_t set;
    for (int i = 0; i < num; i++) begin
      for (int c = 0; c < NUM_CHANNELS; c++) begin
        set[c] = sample_t'($urandom);
      end
      sets.push_back(set);
    end
    pack_model(sets, cur_en);
    // Newest words are the ones lost against a full FIFO
    repeat (dropped) begin
      void'(expected_q.pop_back());
    end
    foreach (sets[i]) begin
      adc_data  = sets[i];
      adc_valid = 1'b1;
      @(posedge axi_aclk);
      #1;
    end
    adc_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while ((expected_q.size() != 0 || m_axis_valid) && n < DRAIN_TIMEOUT) begin
      @(posedge axi_aclk);
      #1;
      n++;
    end
    if (expected_q.size() != 0 || m_axis_valid) begin
      errors++;
      $display("Stream did not drain in time, %0d words still expected",
               expected_q.size());
    end
  endtask

  task automatic end_test(input string name, input int err_mark);
    if (errors == err_mark) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d errors", name, errors - err_mark);
    end
  endtask

  // ************************************************************************
  // Test sequence
  // ************************************************************************
  initial begin
    int err_mark;
    int rx_mark;

    void'($urandom(67));
    rst_n         = 1'b0;
    s_axi_awvalid = 1'b0;
    s_axi_awaddr  = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '0;
    s_axi_bready  = 1'b0;
    s_axi_arvalid = 1'b0;
    s_axi_araddr  = '0;
    s_axi_rready  = 1'b0;
    adc_valid     = 1'b0;
    adc_data      = '0;
    m_axis_ready  = 1'b0;
    repeat (3) @(posedge axi_aclk);
    #1;
    rst_n = 1'b1;

    err_mark = errors;
    read_expect(REG_ID, CORE_ID, RESP_OKAY, "REG_ID");
    read_expect(REG_CHAN_ENABLE, AXI_DW'(ENABLE_RESET), RESP_OKAY, "REG_CHAN_ENABLE");
    read_expect(REG_STATUS, 0, RESP_OKAY, "REG_STATUS");
    read_expect(REG_WORD_COUNT, 0, RESP_OKAY, "REG_WORD_COUNT");
    end_test("1 reset and ID", err_mark);

    err_mark = errors;
    ready_mode = READY_RANDOM;
    send_sample_sets(40, 0);
    wait_drain();
    read_expect(REG_WORD_COUNT, 40, RESP_OKAY, "REG_WORD_COUNT");
    end_test("2 full packing", err_mark);

    // 22 samples leave a partial word that the next enable change drops
    err_mark = errors;
    set_enables(4'b0101);
    read_expect(REG_CHAN_ENABLE, 32'h5, RESP_OKAY, "REG_CHAN_ENABLE");
    send_sample_sets(11, 0);
    wait_drain();
    set_enables(4'b1011);
    send_sample_sets(13, 0);
    wait_drain();
    end_test("3 channel subsets", err_mark);

    err_mark = errors;
    ready_mode = READY_LOW;
    set_enables(4'b1111);
    write_expect(REG_WORD_COUNT, 0, RESP_OKAY, "REG_WORD_COUNT write");
    rx_mark = rx_count;
    send_sample_sets(20, 20 - FIFO_DEPTH);
    read_expect(REG_WORD_COUNT, FIFO_DEPTH, RESP_OKAY, "REG_WORD_COUNT");
    read_expect(REG_STATUS, 1, RESP_OKAY, "REG_STATUS");
    ready_mode = READY_HIGH;
    wait_drain();
    check_value("words received", rx_count - rx_mark, FIFO_DEPTH);
    write_expect(REG_STATUS, 1, RESP_OKAY, "REG_STATUS write");
    read_expect(REG_STATUS, 0, RESP_OKAY, "REG_STATUS");
    end_test("4 back-pressure and overflow", err_mark);

    // Register state left by the previous test is known
    err_mark = errors;
    read_expect(32'h40, 0, RESP_SLVERR, "unmapped read");
    write_expect(32'h40, 32'h0000_0005, RESP_SLVERR, "unmapped write");
    read_expect(REG_ID, CORE_ID, RESP_OKAY, "REG_ID");
    read_expect(REG_CHAN_ENABLE, AXI_DW'(cur_en), RESP_OKAY, "REG_CHAN_ENABLE");
    read_expect(REG_STATUS, 0, RESP_OKAY, "REG_STATUS");
    read_expect(REG_WORD_COUNT, FIFO_DEPTH, RESP_OKAY, "REG_WORD_COUNT");
    end_test("5 unmapped access", err_mark);

    err_mark = errors;
    write_expect(REG_WORD_COUNT, 0, RESP_OKAY, "REG_WORD_COUNT write");
    read_expect(REG_WORD_COUNT, 0, RESP_OKAY, "REG_WORD_COUNT");
    ready_mode = READY_RANDOM;
    send_sample_sets(4, 0);
    wait_drain();
    read_expect(REG_WORD_COUNT, 4, RESP_OKAY, "REG_WORD_COUNT");
    end_test("6 count clear", err_mark);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
adc_pkg.sv
adc_regs.sv
adc_cpack.sv
adc_word_fifo.sv
adc_capture_top.sv
adc_capture_sva.sv
tb_adc_capture.sv
